//--- list.f
source/alu_pkg.sv
source/mul_unit.sv
source/int_divider.sv
source/alu.sv
source/exec_stage.sv
sim/tb_exec_stage.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status follows the pass line in the simulator output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_exec_stage.sv
// Table-driven testbench for the execute stage; run as top module through the file list
`timescale 1ns/10ps

module tb_exec_stage
  import alu_pkg::*;
;

  localparam int NUM_RANDOM = 60;  // Random rows after the corner rows
  localparam int TIMEOUT    = 60;  // Cycles allowed for any wait

  typedef struct packed {
    alu_op_t    op;
    word_t      a;
    word_t      b;
    word_t      result;
    alu_flags_t flags;
  } row_t;

  logic       clk;
  logic       rst;
  logic       issue;
  alu_req_t   req;
  word_t      result;
  alu_flags_t flags;
  logic       done;
  logic       busy;

  row_t  rows[$];
  word_t lcg_state;
  int    errors;
  int    checks;

  exec_stage u_exec_stage (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .req    (req),
    .result (result),
    .flags  (flags),
    .done   (done),
    .busy   (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Low LCG bits cycle quickly, so only the upper halves are used
  function automatic word_t rand_word();
    word_t hi;
    word_t lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // Expected result straight from the operation rules
  function automatic word_t ref_result(alu_op_t op, word_t a, word_t b);
    logic [63:0] ext;
    logic [63:0] sa64;
    logic [63:0] sb64;
    logic [63:0] prod;
    int          sa;
    int          sb;
    sa64 = {{32{a[31]}}, a};
    sb64 = {{32{b[31]}}, b};
    sa   = a;
    sb   = b;
    case (op)
      OP_AND:    return a & b;
      OP_OR:     return a | b;
      OP_XOR:    return a ^ b;
      OP_NOT:    return ~a;
      OP_ADD:    return a + b;
      OP_SUB:    return a - b;
      OP_SUBU:   return a - b;
      OP_SLL:    return a << b[4:0];
      OP_SRL:    return a >> b[4:0];
      OP_SRA:
      begin
        ext = sa64 >> b[4:0]; // Upper copies of the sign shift in
        return ext[31:0];
      end
      OP_SLT:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      OP_SLTU:   return {31'b0, a < b};
      OP_MUL:
      begin
        prod = sa64 * sb64;
        return prod[31:0];
      end
      OP_MULH:
      begin
        prod = sa64 * sb64;
        return prod[63:32];
      end
      OP_MULHSU:
      begin
        prod = sa64 * {32'b0, b};
        return prod[63:32];
      end
      OP_MULHU:
      begin
        prod = {32'b0, a} * {32'b0, b};
        return prod[63:32];
      end
      OP_DIV:
      begin
        if (b == '0)
          return '1;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff)
          return a;
        return word_t'(sa / sb); // Truncates toward zero
      end
      OP_REM:
      begin
        if (b == '0)
          return a;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff)
          return '0;
        return word_t'(sa % sb); // Sign of the dividend
      end
      OP_DIVU:   return (b == '0) ? '1 : a / b;
      OP_REMU:   return (b == '0) ? a : a % b;
      default:   return '0;
    endcase
  endfunction

  function automatic void add_row(alu_op_t op, word_t a, word_t b, word_t res, logic borrow);
    row_t r;
    r.op             = op;
    r.a              = a;
    r.b              = b;
    r.result         = res;
    r.flags.zero     = (res == '0);
    r.flags.negative = res[31];
    r.flags.borrow   = borrow;
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    alu_op_t op;
    word_t   a;
    word_t   b;
    int      i;
    add_row(OP_AND,  32'hf0f0_00ff, 32'h0ff0_0f0f, 32'h00f0_000f, 1'b0);
    add_row(OP_OR,   32'h1200_0034, 32'h0056_7800, 32'h1256_7834, 1'b0);
    add_row(OP_XOR,  32'hffff_0000, 32'hffff_0000, 32'h0000_0000, 1'b0);
    add_row(OP_NOT,  32'h0000_0000, 32'h1234_5678, 32'hffff_ffff, 1'b0);
    add_row(OP_ADD,  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0);
    add_row(OP_ADD,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
    add_row(OP_SUB,  32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 1'b0); // No borrow outside SUBU
    add_row(OP_SUBU, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 1'b1);
    add_row(OP_SUBU, 32'h0000_0009, 32'h0000_0009, 32'h0000_0000, 1'b0);
    add_row(OP_SUBU, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b0);
    add_row(OP_SLL,  32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 1'b0); // Amount 4
    add_row(OP_SRL,  32'h8000_0000, 32'h0000_001f, 32'h0000_0001, 1'b0);
    add_row(OP_SRA,  32'h8000_0000, 32'h0000_0024, 32'hf800_0000, 1'b0);
    add_row(OP_SRA,  32'h4000_0000, 32'h0000_003e, 32'h0000_0001, 1'b0);
    add_row(OP_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0);
    add_row(OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
    add_row(OP_MUL,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0);
    add_row(OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0);
    add_row(OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0);
    add_row(OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 1'b0);
    add_row(OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b0);
    add_row(OP_DIV,  32'hffff_fff9, 32'h0000_0000, 32'hffff_ffff, 1'b0); // Divide by zero
    add_row(OP_REM,  32'hffff_fff9, 32'h0000_0000, 32'hffff_fff9, 1'b0);
    add_row(OP_DIVU, 32'h0000_1234, 32'h0000_0000, 32'hffff_ffff, 1'b0);
    add_row(OP_REMU, 32'h0000_1234, 32'h0000_0000, 32'h0000_1234, 1'b0);
    add_row(OP_DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0); // Signed overflow
    add_row(OP_REM,  32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b0);
    add_row(OP_DIV,  32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, 1'b0);
    add_row(OP_REM,  32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 1'b0);
    add_row(OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 1'b0);
    add_row(OP_REMU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0);
    add_row(alu_op_t'(5'd20), 32'h1234_5678, 32'h0000_0001, 32'h0000_0000, 1'b0);
    for (i = 0; i < NUM_RANDOM; i++)
    begin
      op = alu_op_t'(5'(i % 20)); // Walks every defined opcode
      a  = rand_word();
      b  = rand_word();
      add_row(op, a, b, ref_result(op, a, b), (op == OP_SUBU) && (a < b));
    end
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t expected);
    checks++;
    if (got !== expected)
    begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < TIMEOUT)
    begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (busy)
    begin
      $display("Timeout at time %0t: busy never fell, stage stuck", $time);
      errors++;
    end
  endtask

  task automatic issue_req(input alu_op_t op, input word_t a, input word_t b);
    req.op = op;
    req.a  = a;
    req.b  = b;
    issue  = 1'b1;
    @(posedge clk);
    #2;
    issue  = 1'b0;
  endtask

  // busy must hold until the done cycle
  task automatic wait_done(output bit seen);
    int cycles;
    cycles = 0;
    while (!done && cycles < TIMEOUT)
    begin
      check_value("busy", 32'(busy), 32'd1);
      @(posedge clk);
      #2;
      cycles++;
    end
    seen = done;
    if (!done)
    begin
      $display("Timeout at time %0t: done did not rise after issue", $time);
      errors++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t cur;
    bit   seen;
    cur = rows[idx];
    wait_idle();
    issue_req(cur.op, cur.a, cur.b);
    wait_done(seen);
    if (seen)
    begin
      check_value($sformatf("row %0d result", idx), result, cur.result);
      check_value($sformatf("row %0d zero", idx), 32'(flags.zero), 32'(cur.flags.zero));
      check_value($sformatf("row %0d negative", idx), 32'(flags.negative),
                  32'(cur.flags.negative));
      check_value($sformatf("row %0d borrow", idx), 32'(flags.borrow), 32'(cur.flags.borrow));
    end
  endtask

  // A second issue during a divide must be dropped
  task automatic issue_while_busy();
    int done_count;
    int cycles;
    bit seen;
    wait_idle();
    issue_req(OP_DIV, 32'hffff_ff9c, 32'h0000_0007); // -100 / 7
    repeat (3)
    begin
      @(posedge clk);
      #2;
    end
    check_value("busy during divide", 32'(busy), 32'd1);
    issue_req(OP_ADD, 32'h0000_0001, 32'h0000_0001);
    wait_done(seen);
    done_count = seen ? 1 : 0;
    if (seen)
      check_value("divide result", result, 32'hffff_fff2);
    for (cycles = 0; cycles < 8; cycles++)
    begin
      @(posedge clk);
      #2;
      if (done)
        done_count++;
    end
    check_value("done pulses", 32'(done_count), 32'd1);
    check_value("busy after divide", 32'(busy), 32'd0);
  endtask

  initial
  begin
    int i;
    issue     = 1'b0;
    req       = '0;
    rst       = 1'b1;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'd33;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    check_value("done after reset", 32'(done), 32'd0);
    check_value("busy after reset", 32'(busy), 32'd0);
    for (i = 0; i < rows.size(); i++)
      run_row(i);
    issue_while_busy();
    $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- source/exec_stage.sv
// Execute stage top level; holds one issued request and signals completion with done
`timescale 1ns/10ps

module exec_stage
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       issue,
  input  alu_req_t   req,
  output word_t      result,
  output alu_flags_t flags,
  output logic       done,
  output logic       busy
);

  alu_req_t req_q;   // Request held for the whole operation
  logic     pending;
  logic     fresh;   // First cycle after capture
  logic     accept;
  logic     stall;

  assign accept = issue && !pending; // Issue while busy is dropped

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pending <= 1'b0;
      fresh   <= 1'b0;
    end
    else
    begin
      fresh <= accept;
      if (accept)
        pending <= 1'b1;
      else if (done)
        pending <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      req_q <= req;
  end

  alu u_alu (
    .clk    (clk),
    .rst    (rst),
    .req    (req_q),
    .fresh  (fresh),
    .result (result),
    .flags  (flags),
    .stall  (stall)
  );

  assign done = pending && !stall;
  assign busy = pending;

  // The divider only runs for a request still held here
  a_stall_busy: assert property (@(posedge clk) disable iff (rst)
    stall |-> busy);

endmodule

//--- source/alu.sv
// Integer ALU with single-cycle ops, multiplier and stalling divider; used by the execute stage
`timescale 1ns/10ps

module alu
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  alu_req_t   req,
  input  logic       fresh,
  output word_t      result,
  output alu_flags_t flags,
  output logic       stall
);

  word_t product_word;
  word_t quotient;
  word_t remainder;
  logic  div_class;
  logic  signed_op;
  logic  start;
  logic  div_busy;
  logic  div_done;
  logic  [4:0] shamt;

  assign shamt     = req.b[4:0]; // Only low 5 bits shift
  assign div_class = (req.op == OP_DIV) || (req.op == OP_DIVU) ||
                     (req.op == OP_REM) || (req.op == OP_REMU);
  assign signed_op = (req.op == OP_DIV) || (req.op == OP_REM);
  assign start     = fresh && div_class; // One pulse per issued divide

  mul_unit u_mul_unit (
    .op           (req.op),
    .a            (req.a),
    .b            (req.b),
    .product_word (product_word)
  );

  int_divider u_int_divider (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .signed_op (signed_op),
    .a         (req.a),
    .b         (req.b),
    .quotient  (quotient),
    .remainder (remainder),
    .div_busy  (div_busy),
    .div_done  (div_done)
  );

  always_comb
  begin
    case (req.op)
      OP_AND:  result = req.a & req.b;
      OP_OR:   result = req.a | req.b;
      OP_ADD:  result = req.a + req.b;
      OP_XOR:  result = req.a ^ req.b;
      OP_SUB:  result = req.a - req.b;
      OP_NOT:  result = ~req.a;
      OP_SLL:  result = req.a << shamt;
      OP_SRL:  result = req.a >> shamt;
      OP_SRA:  result = word_t'($signed(req.a) >>> shamt); // Sign fill
      OP_SLT:  result = {31'b0, $signed(req.a) < $signed(req.b)};
      OP_SLTU: result = {31'b0, req.a < req.b};
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU:
      begin
        result = product_word;
      end
      OP_DIV, OP_DIVU:
      begin
        result = quotient; // Valid once div_done
      end
      OP_REM, OP_REMU:
      begin
        result = remainder;
      end
      OP_SUBU: result = req.a - req.b;
      default: result = '0;
    endcase
  end

  assign flags.zero     = (result == '0);
  assign flags.negative = result[31];
  assign flags.borrow   = (req.op == OP_SUBU) && (req.a < req.b);

  // Hold off completion from start until the divider reports done
  assign stall = (start || div_busy) && !div_done;

  // Single-cycle ops never find the divider running, so they complete at once
  a_no_stall_single: assert property (@(posedge clk) disable iff (rst)
    fresh && !div_class |-> !stall);

endmodule

//--- source/int_divider.sv
// Iterative restoring divider for div, divu, rem and remu; started by the ALU
`timescale 1ns/10ps

module int_divider
  import alu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  signed_op,
  input  word_t a,
  input  word_t b,
  output word_t quotient,
  output word_t remainder,
  output logic  div_busy,
  output logic  div_done
);

  localparam int DIV_STEPS = $bits(word_t); // One quotient bit per step

  div_state_t  state;
  logic [5:0]  count;
  word_t       quo_q;    // Dividend shifts out, quotient shifts in
  word_t       rem_q;    // Partial remainder
  word_t       dvs_q;    // Divisor magnitude
  word_t       a_q;      // Original dividend for corner cases
  logic        neg_quo;
  logic        neg_rem;
  logic        by_zero;
  logic        overflow;
  logic [32:0] shifted;
  logic [32:0] diff;

  // Trial subtract of one restoring step
  assign shifted = {rem_q, quo_q[31]};
  assign diff    = shifted - {1'b0, dvs_q};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= DIV_IDLE;
      count <= '0;
    end
    else
    begin
      case (state)
        DIV_IDLE, DIV_DONE:
        begin
          state <= start ? DIV_RUN : DIV_IDLE;
          count <= '0;
        end
        DIV_RUN:
        begin
          if (count == 6'(DIV_STEPS))
            state <= DIV_DONE; // Fix-up cycle ends the run
          count <= count + 6'd1;
        end
        default:
        begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start && state != DIV_RUN)
    begin
      quo_q    <= (signed_op && a[31]) ? -a : a;
      dvs_q    <= (signed_op && b[31]) ? -b : b;
      rem_q    <= '0;
      a_q      <= a;
      neg_quo  <= signed_op && (a[31] ^ b[31]);
      neg_rem  <= signed_op && a[31]; // Remainder follows sign of a
      by_zero  <= (b == '0);
      overflow <= signed_op && (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    end
    else if (state == DIV_RUN && count != 6'(DIV_STEPS))
    begin
      if (!diff[32])
      begin
        rem_q <= diff[31:0];
        quo_q <= {quo_q[30:0], 1'b1};
      end
      else
      begin
        rem_q <= shifted[31:0]; // Restore
        quo_q <= {quo_q[30:0], 1'b0};
      end
    end
    else if (state == DIV_RUN)
    begin
      // Sign fix-up, with RISC-V corner results taking priority
      if (by_zero)
      begin
        quotient  <= '1;
        remainder <= a_q;
      end
      else if (overflow)
      begin
        quotient  <= a_q;
        remainder <= '0;
      end
      else
      begin
        quotient  <= neg_quo ? -quo_q : quo_q;
        remainder <= neg_rem ? -rem_q : rem_q;
      end
    end
  end

  assign div_busy = (state == DIV_RUN);
  assign div_done = (state == DIV_DONE);

  a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !div_busy);
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) div_done |=> !div_done);

endmodule

//--- source/mul_unit.sv
// Single-cycle multiplier for the four RV32M multiply opcodes, used inside the ALU
`timescale 1ns/10ps

module mul_unit
  import alu_pkg::*;
(
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   product_word
);

  logic               a_signed;
  logic               b_signed;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [65:0] product;

  // mulhsu treats only a as signed; mul low word is sign agnostic
  assign a_signed = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU);
  assign b_signed = (op == OP_MUL) || (op == OP_MULH);

  assign a_ext = {a_signed & a[31], a}; // Sign or zero extend
  assign b_ext = {b_signed & b[31], b};

  // One 33x33 signed product covers all operand sign mixes
  assign product = a_ext * b_ext;

  always_comb
  begin
    case (op)
      OP_MUL:
      begin
        product_word = product[31:0];
      end
      OP_MULH, OP_MULHSU, OP_MULHU:
      begin
        product_word = product[63:32]; // Upper word of 64-bit result
      end
      default:
      begin
        product_word = '0;
      end
    endcase
  end

endmodule

//--- source/alu_pkg.sv
// Shared types for the execute block; imported by every RTL module that needs them
package alu_pkg;

  typedef logic [31:0] word_t; // Operand and result word

  // Opcode numbering matches the decoder control field
  typedef enum logic [4:0] {
    OP_AND    = 5'd0,
    OP_OR     = 5'd1,
    OP_ADD    = 5'd2,
    OP_XOR    = 5'd3,
    OP_SUB    = 5'd4,
    OP_NOT    = 5'd5,
    OP_SLL    = 5'd6,
    OP_SRL    = 5'd7,
    OP_SRA    = 5'd8,
    OP_SLT    = 5'd9,
    OP_SLTU   = 5'd10,
    OP_MUL    = 5'd11,  // Low word of product
    OP_MULH   = 5'd12,  // High word, signed x signed
    OP_MULHSU = 5'd13,  // High word, signed x unsigned
    OP_MULHU  = 5'd14,  // High word, unsigned x unsigned
    OP_DIV    = 5'd15,
    OP_DIVU   = 5'd16,
    OP_REM    = 5'd17,
    OP_REMU   = 5'd18,
    OP_SUBU   = 5'd19   // Unsigned subtract with borrow out
  } alu_op_t;

  // One issued operation
  typedef struct packed {
    alu_op_t op;
    word_t   a;
    word_t   b;
  } alu_req_t;

  typedef struct packed {
    logic zero;      // Result is all zeros
    logic negative;  // Result bit 31
    logic borrow;    // Only for OP_SUBU
  } alu_flags_t;

  // Iterative divider sequencing
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_t;

endpackage
